// File: Bender.yml
package:
  name: rv_decode

sources:
  - decode_pkg.sv
  - decode_cfg.sv
  - imm_gen.sv
  - instr_decoder.sv
  - pc_ctrl.sv
  - rv_decode_top.sv
  - target: test
    files:
      - rv_decode_assertions.sv
      - tb_rv_decode.sv

// File: decode_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module decode_cfg (
	input  logic clk,
	input  logic rst_n,
	input  logic cfg_req_i,
	input  logic cfg_m_mode_i,
	input  logic cfg_trap_wfi_i,
	output logic cfg_ack_o,
	output logic m_mode_o,
	output logic trap_wfi_o
);

	logic capture;

	// a request seen while ack is still low is the opening phase of a write
	assign capture = cfg_req_i && !cfg_ack_o;

	// ------------------------------
	// four-phase write port
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg_ack_o <= 1'b0;
		end else begin
			// ack follows the request one edge later in both directions
			cfg_ack_o <= cfg_req_i;
		end
	end

	// core comes out of reset in M mode with wfi allowed
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_mode_o   <= 1'b1;
			trap_wfi_o <= 1'b0;
		end else if (capture) begin
			m_mode_o   <= cfg_m_mode_i;
			trap_wfi_o <= cfg_trap_wfi_i;
		end
	end

endmodule

`default_nettype wire

// File: decode_pkg.sv
`default_nettype none

package decode_pkg;

	parameter int XLEN       = 32;
	parameter int REG_ADDR_W = 5;

	parameter logic [XLEN-1:0] DEFAULT_RESET_VECTOR = 32'h0000_0000;

	// ------------------------------
	// major opcode, instruction bits 6:2
	// ------------------------------
	typedef enum logic [4:0] {
		OPC_LOAD     = 5'b00000,
		OPC_MISC_MEM = 5'b00011,
		OPC_OP_IMM   = 5'b00100,
		OPC_AUIPC    = 5'b00101,
		OPC_STORE    = 5'b01000,
		OPC_OP       = 5'b01100,
		OPC_LUI      = 5'b01101,
		OPC_BRANCH   = 5'b11000,
		OPC_JALR     = 5'b11001,
		OPC_JAL      = 5'b11011,
		OPC_SYSTEM   = 5'b11100
	} opcode_e;

	// ------------------------------
	// execute stage controls
	// ------------------------------
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_LT, ALU_LTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_RS2, ALU_MULDIV
	} alu_op_e;

	typedef enum logic {SRC_A_RS1, SRC_A_PC} alu_src_a_e;

	typedef enum logic {SRC_B_RS2, SRC_B_IMM} alu_src_b_e;

	typedef enum logic [3:0] {
		MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
		MEM_SB, MEM_SH, MEM_SW
	} mem_op_e;

	// order follows funct3 of the M extension
	typedef enum logic [2:0] {
		MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU,
		MUL_DIV, MUL_DIVU, MUL_REM, MUL_REMU
	} mul_op_e;

	typedef enum logic [1:0] {BCOND_NEVER, BCOND_ALWAYS, BCOND_ZERO, BCOND_NZERO} branch_cond_e;

	typedef enum logic [1:0] {CSR_W, CSR_S, CSR_C} csr_wtype_e;

	typedef enum logic [2:0] {
		EXC_NONE, EXC_INSTR_ILLEGAL, EXC_INSTR_FAULT, EXC_ECALL_M,
		EXC_ECALL_U, EXC_EBREAK, EXC_MRET, EXC_REFETCH
	} except_e;

endpackage

`default_nettype wire

// File: imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen import decode_pkg::*; (
	input  logic [XLEN-1:0] instr_i,
	output logic [XLEN-1:0] imm_i_o,
	output logic [XLEN-1:0] imm_u_o,
	output logic [XLEN-1:0] addr_offs_o
);

	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_j;
	opcode_e         opcode;

	assign opcode = opcode_e'(instr_i[6:2]);

	// all formats take their sign from bit 31
	assign imm_i_o = {{(XLEN-11){instr_i[31]}}, instr_i[30:20]};
	assign imm_s   = {{(XLEN-11){instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
	assign imm_b   = {{(XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u_o = {instr_i[31:12], 12'h000};
	assign imm_j   = {{(XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	// ------------------------------
	// address offset for the AGU
	// ------------------------------
	always_comb begin
		case (opcode)
			OPC_JAL:    addr_offs_o = imm_j;
			OPC_BRANCH: addr_offs_o = imm_b;
			OPC_STORE:  addr_offs_o = imm_s;
			OPC_JALR:   addr_offs_o = imm_i_o;
			OPC_LOAD:   addr_offs_o = imm_i_o;
			default:    addr_offs_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import decode_pkg::*; #(
	parameter bit EXTENSION_M = 1'b1,
	parameter bit U_MODE      = 1'b0
) (
	input  logic [XLEN-1:0]       instr_i,
	input  logic                  instr_vld_i,
	input  logic                  instr_err_i,
	input  logic                  starved_i,
	input  logic                  m_mode_i,
	input  logic                  trap_wfi_i,
	input  logic [XLEN-1:0]       imm_i_i,
	input  logic [XLEN-1:0]       imm_u_i,
	output logic [REG_ADDR_W-1:0] rs1_o,
	output logic [REG_ADDR_W-1:0] rs2_o,
	output logic [REG_ADDR_W-1:0] rd_o,
	output logic [XLEN-1:0]       imm_o,
	output alu_src_a_e            alu_src_a_o,
	output alu_src_b_e            alu_src_b_o,
	output alu_op_e               alu_op_o,
	output mem_op_e               mem_op_o,
	output mul_op_e               mul_op_o,
	output branch_cond_e          branch_cond_o,
	output logic                  addr_is_regoffs_o,
	output logic                  csr_ren_o,
	output logic                  csr_wen_o,
	output csr_wtype_e            csr_wtype_o,
	output logic                  csr_w_imm_o,
	output except_e               except_o,
	output logic                  sleep_wfi_o,
	output logic                  fence_i_o
);

	localparam logic [REG_ADDR_W-1:0] X0 = '0;

	logic [2:0]            funct3;
	logic [6:0]            funct7;
	opcode_e               opcode;
	logic                  invalid;
	logic                  bus_fault;
	logic [REG_ADDR_W-1:0] raw_rs1;
	logic [REG_ADDR_W-1:0] raw_rs2;
	logic [REG_ADDR_W-1:0] raw_rd;
	mem_op_e               raw_mem_op;
	branch_cond_e          raw_branch_cond;
	logic                  raw_csr_ren;
	logic                  raw_csr_wen;
	except_e               raw_except;
	logic                  raw_sleep_wfi;

	assign funct3    = instr_i[14:12];
	assign funct7    = instr_i[31:25];
	assign opcode    = opcode_e'(instr_i[6:2]);
	assign bus_fault = instr_vld_i && instr_err_i;

	// alt selects SUB over ADD and SRA over SRL
	function automatic alu_op_e base_alu_op(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		case (f3)
			3'b000:  op = alt ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_LT;
			3'b011:  op = ALU_LTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	// ------------------------------
	// raw decode table
	// ------------------------------
	always_comb begin
		raw_rs1           = instr_i[19:15];
		raw_rs2           = instr_i[24:20];
		raw_rd            = instr_i[11:7];
		imm_o             = imm_i_i;
		alu_src_a_o       = SRC_A_RS1;
		alu_src_b_o       = SRC_B_RS2;
		alu_op_o          = ALU_ADD;
		raw_mem_op        = MEM_NONE;
		mul_op_o          = MUL_MUL;
		raw_branch_cond   = BCOND_NEVER;
		addr_is_regoffs_o = 1'b0;
		raw_csr_ren       = 1'b0;
		raw_csr_wen       = 1'b0;
		csr_wtype_o       = CSR_W;
		csr_w_imm_o       = 1'b0;
		raw_except        = EXC_NONE;
		raw_sleep_wfi     = 1'b0;
		fence_i_o         = 1'b0;
		// only 32-bit encodings are accepted
		invalid           = instr_i[1:0] != 2'b11;

		case (opcode)
			OPC_LUI, OPC_AUIPC: begin
				alu_op_o    = opcode == OPC_LUI ? ALU_RS2 : ALU_ADD;
				alu_src_a_o = opcode == OPC_LUI ? SRC_A_RS1 : SRC_A_PC;
				alu_src_b_o = SRC_B_IMM;
				imm_o       = imm_u_i;
				raw_rs1     = X0;
				raw_rs2     = X0;
			end
			OPC_JAL, OPC_JALR: begin
				// the ALU produces the link value PC+4
				invalid           = invalid || (opcode == OPC_JALR && funct3 != 3'b000);
				raw_branch_cond   = BCOND_ALWAYS;
				addr_is_regoffs_o = opcode == OPC_JALR;
				alu_src_a_o       = SRC_A_PC;
				alu_src_b_o       = SRC_B_IMM;
				imm_o             = 32'h0000_0004;
				raw_rs2           = X0;
				if (opcode == OPC_JAL) begin
					raw_rs1 = X0;
				end
			end
			OPC_BRANCH: begin
				invalid  = invalid || funct3[2:1] == 2'b01;
				raw_rd   = X0;
				alu_op_o = !funct3[2] ? ALU_SUB : (funct3[1] ? ALU_LTU : ALU_LT);
				// BEQ/BGE/BGEU take on a zero result, the rest on nonzero
				raw_branch_cond = funct3[0] == funct3[2] ? BCOND_ZERO : BCOND_NZERO;
			end
			OPC_LOAD: begin
				addr_is_regoffs_o = 1'b1;
				raw_rs2           = X0;
				case (funct3)
					3'b000:  raw_mem_op = MEM_LB;
					3'b001:  raw_mem_op = MEM_LH;
					3'b010:  raw_mem_op = MEM_LW;
					3'b100:  raw_mem_op = MEM_LBU;
					3'b101:  raw_mem_op = MEM_LHU;
					default: invalid = 1'b1;
				endcase
			end
			OPC_STORE: begin
				addr_is_regoffs_o = 1'b1;
				alu_op_o          = ALU_RS2;
				raw_rd            = X0;
				case (funct3)
					3'b000:  raw_mem_op = MEM_SB;
					3'b001:  raw_mem_op = MEM_SH;
					3'b010:  raw_mem_op = MEM_SW;
					default: invalid = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				alu_op_o    = base_alu_op(funct3, funct3 == 3'b101 && funct7[5]);
				alu_src_b_o = SRC_B_IMM;
				raw_rs2     = X0;
				if (funct3 == 3'b001 && funct7 != 7'h00) begin
					invalid = 1'b1;
				end
				if (funct3 == 3'b101 && funct7 != 7'h00 && funct7 != 7'h20) begin
					invalid = 1'b1;
				end
			end
			OPC_OP: begin
				if (funct7 == 7'h00) begin
					alu_op_o = base_alu_op(funct3, 1'b0);
				end else if (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
					alu_op_o = base_alu_op(funct3, 1'b1);
				end else if (funct7 == 7'h01 && EXTENSION_M) begin
					alu_op_o = ALU_MULDIV;
					mul_op_o = mul_op_e'(funct3);
				end else begin
					invalid = 1'b1;
				end
			end
			OPC_MISC_MEM: begin
				if (instr_i == 32'h0000_100f) begin
					fence_i_o  = 1'b1;
					raw_except = EXC_REFETCH;
				end else if (funct3 == 3'b000 && raw_rs1 == X0 && raw_rd == X0) begin
					// plain fence executes as a nop
					raw_rs2 = X0;
				end else begin
					invalid = 1'b1;
				end
			end
			OPC_SYSTEM: begin
				if (funct3 == 3'b000) begin
					raw_rs1 = X0;
					raw_rs2 = X0;
					raw_rd  = X0;
					case (instr_i)
						32'h0000_0073: raw_except = m_mode_i || !U_MODE ? EXC_ECALL_M : EXC_ECALL_U;
						32'h0010_0073: raw_except = EXC_EBREAK;
						32'h3020_0073: begin
							invalid    = invalid || !m_mode_i;
							raw_except = EXC_MRET;
						end
						32'h1050_0073: begin
							invalid       = invalid || trap_wfi_i;
							raw_sleep_wfi = 1'b1;
						end
						default: invalid = 1'b1;
					endcase
				end else begin
					csr_w_imm_o = funct3[2];
					case (funct3[1:0])
						2'b01:   csr_wtype_o = CSR_W;
						2'b10:   csr_wtype_o = CSR_S;
						2'b11:   csr_wtype_o = CSR_C;
						default: invalid = 1'b1;
					endcase
					// a write with x0 as destination has no read side effect
					raw_csr_wen = funct3[1:0] == 2'b01 ? 1'b1 : |raw_rs1;
					raw_csr_ren = funct3[1:0] == 2'b01 ? |raw_rd : 1'b1;
				end
			end
			default: invalid = 1'b1;
		endcase
	end

	// ------------------------------
	// gating on validity and faults
	// ------------------------------
	always_comb begin
		rs1_o         = raw_rs1;
		rs2_o         = raw_rs2;
		rd_o          = raw_rd;
		mem_op_o      = raw_mem_op;
		branch_cond_o = raw_branch_cond;
		csr_ren_o     = raw_csr_ren;
		csr_wen_o     = raw_csr_wen;
		except_o      = raw_except;
		sleep_wfi_o   = raw_sleep_wfi;
		if (invalid || starved_i || bus_fault) begin
			rs1_o         = X0;
			rs2_o         = X0;
			rd_o          = X0;
			mem_op_o      = MEM_NONE;
			branch_cond_o = BCOND_NEVER;
			csr_ren_o     = 1'b0;
			csr_wen_o     = 1'b0;
			except_o      = EXC_NONE;
			sleep_wfi_o   = 1'b0;
			if (bus_fault) begin
				except_o = EXC_INSTR_FAULT;
			end else if (invalid && !starved_i) begin
				except_o = EXC_INSTR_ILLEGAL;
			end
		end
	end

endmodule

`default_nettype wire

// File: pc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pc_ctrl import decode_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_VECTOR = DEFAULT_RESET_VECTOR
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            instr_vld_i,
	input  logic            x_stall_i,
	input  logic            jump_now_i,
	input  logic [XLEN-1:0] jump_target_i,
	output logic            instr_use_o,
	output logic            starved_o,
	output logic [XLEN-1:0] pc_o
);

	logic [XLEN-1:0] pc_seq_next;

	// ------------------------------
	// fetch handshake
	// ------------------------------
	assign starved_o   = !instr_vld_i;
	assign instr_use_o = !starved_o && !x_stall_i;

	assign pc_seq_next = pc_o + 32'h0000_0004;

	// ------------------------------
	// PC of the instruction in decode
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_o <= RESET_VECTOR;
		end else if (jump_now_i) begin
			// a redirect wins even when decode is stalled
			pc_o <= jump_target_i;
		end else if (instr_use_o) begin
			pc_o <= pc_seq_next;
		end
	end

endmodule

`default_nettype wire

// File: rv_decode_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_assertions import decode_pkg::*; (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  cfg_req_i,
	input logic                  cfg_ack_o,
	input logic                  instr_use_o,
	input logic                  x_stall_i,
	input logic [REG_ADDR_W-1:0] rd_o,
	input except_e               except_o
);

	// ------------------------------
	// four-phase config port
	// ------------------------------
	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		cfg_ack_o |-> $past(cfg_req_i))
		else $error("cfg_ack_o high without a preceding request");

	// ack drops on the edge after the request drops
	ack_follows_release: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(cfg_req_i) |=> !cfg_ack_o)
		else $error("cfg_ack_o still high after the request was released");

	no_use_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
		x_stall_i |-> !instr_use_o)
		else $error("instruction used while execute stalls");

	illegal_has_no_rd: assert property (@(posedge clk) disable iff (!rst_n)
		except_o == EXC_INSTR_ILLEGAL |-> rd_o == '0)
		else $error("illegal instruction keeps a destination register");

endmodule

bind rv_decode_top rv_decode_assertions u_assertions (.*);

`default_nettype wire

// File: rv_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_top import decode_pkg::*; #(
	parameter bit              EXTENSION_M  = 1'b1,
	parameter bit              U_MODE       = 1'b1,
	parameter logic [XLEN-1:0] RESET_VECTOR = DEFAULT_RESET_VECTOR
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [XLEN-1:0]       instr_i,
	input  logic                  instr_vld_i,
	input  logic                  instr_err_i,
	output logic                  instr_use_o,
	output logic [XLEN-1:0]       pc_o,
	input  logic                  x_stall_i,
	input  logic                  jump_now_i,
	input  logic [XLEN-1:0]       jump_target_i,
	input  logic                  cfg_req_i,
	input  logic                  cfg_m_mode_i,
	input  logic                  cfg_trap_wfi_i,
	output logic                  cfg_ack_o,
	output logic [REG_ADDR_W-1:0] rs1_o,
	output logic [REG_ADDR_W-1:0] rs2_o,
	output logic [REG_ADDR_W-1:0] rd_o,
	output logic [XLEN-1:0]       imm_o,
	output alu_src_a_e            alu_src_a_o,
	output alu_src_b_e            alu_src_b_o,
	output alu_op_e               alu_op_o,
	output mem_op_e               mem_op_o,
	output mul_op_e               mul_op_o,
	output branch_cond_e          branch_cond_o,
	output logic [XLEN-1:0]       addr_offs_o,
	output logic                  addr_is_regoffs_o,
	output logic                  csr_ren_o,
	output logic                  csr_wen_o,
	output csr_wtype_e            csr_wtype_o,
	output logic                  csr_w_imm_o,
	output except_e               except_o,
	output logic                  sleep_wfi_o,
	output logic                  fence_i_o
);

	logic            m_mode;
	logic            trap_wfi;
	logic            starved;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_u;

	decode_cfg u_cfg (
		.clk            (clk),
		.rst_n          (rst_n),
		.cfg_req_i      (cfg_req_i),
		.cfg_m_mode_i   (cfg_m_mode_i),
		.cfg_trap_wfi_i (cfg_trap_wfi_i),
		.cfg_ack_o      (cfg_ack_o),
		.m_mode_o       (m_mode),
		.trap_wfi_o     (trap_wfi)
	);

	imm_gen u_imm_gen (
		.instr_i     (instr_i),
		.imm_i_o     (imm_i),
		.imm_u_o     (imm_u),
		.addr_offs_o (addr_offs_o)
	);

	instr_decoder #(
		.EXTENSION_M (EXTENSION_M),
		.U_MODE      (U_MODE)
	) u_decoder (
		.instr_i           (instr_i),
		.instr_vld_i       (instr_vld_i),
		.instr_err_i       (instr_err_i),
		.starved_i         (starved),
		.m_mode_i          (m_mode),
		.trap_wfi_i        (trap_wfi),
		.imm_i_i           (imm_i),
		.imm_u_i           (imm_u),
		.rs1_o             (rs1_o),
		.rs2_o             (rs2_o),
		.rd_o              (rd_o),
		.imm_o             (imm_o),
		.alu_src_a_o       (alu_src_a_o),
		.alu_src_b_o       (alu_src_b_o),
		.alu_op_o          (alu_op_o),
		.mem_op_o          (mem_op_o),
		.mul_op_o          (mul_op_o),
		.branch_cond_o     (branch_cond_o),
		.addr_is_regoffs_o (addr_is_regoffs_o),
		.csr_ren_o         (csr_ren_o),
		.csr_wen_o         (csr_wen_o),
		.csr_wtype_o       (csr_wtype_o),
		.csr_w_imm_o       (csr_w_imm_o),
		.except_o          (except_o),
		.sleep_wfi_o       (sleep_wfi_o),
		.fence_i_o         (fence_i_o)
	);

	pc_ctrl #(
		.RESET_VECTOR (RESET_VECTOR)
	) u_pc_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_vld_i   (instr_vld_i),
		.x_stall_i     (x_stall_i),
		.jump_now_i    (jump_now_i),
		.jump_target_i (jump_target_i),
		.instr_use_o   (instr_use_o),
		.starved_o     (starved),
		.pc_o          (pc_o)
	);

endmodule

`default_nettype wire

// File: sources.f
decode_pkg.sv
decode_cfg.sv
imm_gen.sv
instr_decoder.sv
pc_ctrl.sv
rv_decode_top.sv
rv_decode_assertions.sv
tb_rv_decode.sv

// File: tb_rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decode import decode_pkg::*; ();

	localparam logic [XLEN-1:0] RESET_VEC   = 32'h0000_1000;
	localparam bit              EXT_M       = 1'b1;
	localparam int              N_RANDOM    = 600;
	localparam int              ACK_TIMEOUT = 20;

	logic                  clk;
	logic                  rst_n;
	logic [XLEN-1:0]       instr_i;
	logic                  instr_vld_i;
	logic                  instr_err_i;
	logic                  instr_use_o;
	logic [XLEN-1:0]       pc_o;
	logic                  x_stall_i;
	logic                  jump_now_i;
	logic [XLEN-1:0]       jump_target_i;
	logic                  cfg_req_i;
	logic                  cfg_m_mode_i;
	logic                  cfg_trap_wfi_i;
	logic                  cfg_ack_o;
	logic [REG_ADDR_W-1:0] rs1_o;
	logic [REG_ADDR_W-1:0] rs2_o;
	logic [REG_ADDR_W-1:0] rd_o;
	logic [XLEN-1:0]       imm_o;
	alu_src_a_e            alu_src_a_o;
	alu_src_b_e            alu_src_b_o;
	alu_op_e               alu_op_o;
	mem_op_e               mem_op_o;
	mul_op_e               mul_op_o;
	branch_cond_e          branch_cond_o;
	logic [XLEN-1:0]       addr_offs_o;
	logic                  addr_is_regoffs_o;
	logic                  csr_ren_o;
	logic                  csr_wen_o;
	csr_wtype_e            csr_wtype_o;
	logic                  csr_w_imm_o;
	except_e               except_o;
	logic                  sleep_wfi_o;
	logic                  fence_i_o;

	// reference model state
	logic [REG_ADDR_W-1:0] e_rs1;
	logic [REG_ADDR_W-1:0] e_rs2;
	logic [REG_ADDR_W-1:0] e_rd;
	logic [XLEN-1:0]       e_imm;
	logic [XLEN-1:0]       e_offs;
	logic                  e_imm_chk;
	logic                  e_bad;
	logic                  e_csr;
	logic                  e_ren;
	logic                  e_wen;
	logic                  e_wimm;
	logic                  e_wfi;
	logic                  e_regoffs;
	logic                  e_fence;
	alu_src_a_e            e_src_a;
	alu_src_b_e            e_src_b;
	alu_op_e               e_alu;
	mem_op_e               e_mem;
	mul_op_e               e_mul;
	branch_cond_e          e_bcond;
	csr_wtype_e            e_wtype;
	except_e               e_exc;
	logic [XLEN-1:0]       model_pc;
	logic                  model_m_mode;
	logic                  model_trap_wfi;
	logic [31:0]           rng_state;
	int                    errors;
	int                    timeouts;
	string                 phase;

	rv_decode_top #(
		.EXTENSION_M  (EXT_M),
		.U_MODE       (1'b1),
		.RESET_VECTOR (RESET_VEC)
	) u_dut (.*);

	always #10 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// alt picks the subtract and arithmetic shift variants
	function automatic alu_op_e alu_for_f3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0:    return alt ? ALU_SUB : ALU_ADD;
			3'd1:    return ALU_SLL;
			3'd2:    return ALU_LT;
			3'd3:    return ALU_LTU;
			3'd4:    return ALU_XOR;
			3'd5:    return alt ? ALU_SRA : ALU_SRL;
			3'd6:    return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	// ------------------------------
	// stimulus words
	// ------------------------------
	function automatic logic [31:0] make_word();
		logic [31:0] r;
		logic [31:0] w;
		logic [2:0]  sel;
		r = next_rand();
		w = next_rand();
		sel = 3'(r % 5);
		case (r % 12)
			0: w[6:0] = {r[5] ? 5'b01101 : 5'b00101, 2'b11};
			1: w[6:0] = 7'b1101111;
			2: begin
				w[6:0] = 7'b1100111;
				w[14:12] = 3'b000;
			end
			3: begin
				w[6:0] = 7'b1100011;
				w[14] = w[14] | w[13];
			end
			4: begin
				w[6:0] = 7'b0000011;
				w[14:12] = sel > 3'd2 ? sel + 3'd1 : sel;
			end
			5: begin
				w[6:0] = 7'b0100011;
				w[14:12] = 3'(r % 3);
			end
			6: begin
				w[6:0] = 7'b0010011;
				if (w[13:12] == 2'b01) begin
					w[31:25] = {1'b0, w[30] & w[14], 5'b00000};
				end
			end
			7: begin
				w[6:0] = 7'b0110011;
				w[31:25] = {1'b0, w[30] && (w[14:12] == 3'd0 || w[14:12] == 3'd5), 5'b00000};
			end
			8: begin
				w[6:0] = 7'b0110011;
				w[31:25] = 7'h01;
			end
			9: begin
				// x0 operands are made common so the CSR side effect rules get exercised
				w[6:0] = 7'b1110011;
				w[14:12] = {r[5], 2'(r % 3) + 2'd1};
				if (r[7:6] == 2'b00) begin
					w[19:15] = '0;
				end
				if (r[9:8] == 2'b00) begin
					w[11:7] = '0;
				end
			end
			10: begin
				if (r[4]) begin
					w[1:0] = r[5] ? 2'b10 : {1'b0, r[6]};
				end else begin
					w[6:0] = {r[5] ? 5'b00010 : 5'b01010, 2'b11};
				end
			end
			default: w = w;
		endcase
		return w;
	endfunction

	// ------------------------------
	// reference decode
	// ------------------------------
	task automatic expect_decode(input logic [31:0] w);
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] imm_i;
		f3 = w[14:12];
		f7 = w[31:25];
		imm_i = {{20{w[31]}}, w[31:20]};
		e_rs1 = w[19:15];
		e_rs2 = w[24:20];
		e_rd = w[11:7];
		e_imm = imm_i;
		e_imm_chk = 1'b0;
		e_offs = '0;
		e_src_a = SRC_A_RS1;
		e_src_b = SRC_B_RS2;
		e_regoffs = 1'b0;
		e_fence = 1'b0;
		e_alu = ALU_ADD;
		e_mem = MEM_NONE;
		e_mul = MUL_MUL;
		e_bcond = BCOND_NEVER;
		e_csr = 1'b0;
		e_ren = 1'b0;
		e_wen = 1'b0;
		e_wtype = CSR_W;
		e_wimm = 1'b0;
		e_exc = EXC_NONE;
		e_wfi = 1'b0;
		e_bad = w[1:0] != 2'b11;
		case (w[6:2])
			5'b01101, 5'b00101: begin
				e_rs1 = '0;
				e_rs2 = '0;
				e_imm = {w[31:12], 12'h000};
				e_imm_chk = 1'b1;
				e_alu = w[5] ? ALU_RS2 : ALU_ADD;
				// AUIPC adds the PC, LUI passes the immediate
				e_src_a = w[5] ? SRC_A_RS1 : SRC_A_PC;
				e_src_b = SRC_B_IMM;
			end
			5'b11011, 5'b11001: begin
				// jumps link PC+4 through the ALU
				e_rs2 = '0;
				e_imm = 32'd4;
				e_imm_chk = 1'b1;
				e_bcond = BCOND_ALWAYS;
				e_src_a = SRC_A_PC;
				e_src_b = SRC_B_IMM;
				if (w[3]) begin
					e_rs1 = '0;
					e_offs = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
				end else begin
					e_offs = imm_i;
					e_regoffs = 1'b1;
					e_bad = e_bad || f3 != 3'b000;
				end
			end
			5'b11000: begin
				e_rd = '0;
				e_offs = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
				case (f3[2:1])
					2'b00:   e_alu = ALU_SUB;
					2'b10:   e_alu = ALU_LT;
					2'b11:   e_alu = ALU_LTU;
					default: e_bad = 1'b1;
				endcase
				e_bcond = (f3[0] ^ f3[2]) ? BCOND_NZERO : BCOND_ZERO;
			end
			5'b00000: begin
				e_rs2 = '0;
				e_offs = imm_i;
				e_imm_chk = 1'b1;
				e_regoffs = 1'b1;
				case (f3)
					3'd0:    e_mem = MEM_LB;
					3'd1:    e_mem = MEM_LH;
					3'd2:    e_mem = MEM_LW;
					3'd4:    e_mem = MEM_LBU;
					3'd5:    e_mem = MEM_LHU;
					default: e_bad = 1'b1;
				endcase
			end
			5'b01000: begin
				e_rd = '0;
				e_alu = ALU_RS2;
				e_regoffs = 1'b1;
				e_offs = {{20{w[31]}}, w[31:25], w[11:7]};
				case (f3)
					3'd0:    e_mem = MEM_SB;
					3'd1:    e_mem = MEM_SH;
					3'd2:    e_mem = MEM_SW;
					default: e_bad = 1'b1;
				endcase
			end
			5'b00100: begin
				e_rs2 = '0;
				e_imm_chk = 1'b1;
				e_src_b = SRC_B_IMM;
				e_alu = alu_for_f3(f3, f3 == 3'd5 && f7 == 7'h20);
				e_bad = e_bad || (f3 == 3'd1 && f7 != 7'h00);
				e_bad = e_bad || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
			end
			5'b01100: begin
				if (f7 == 7'h01) begin
					e_alu = ALU_MULDIV;
					e_mul = mul_op_e'(f3);
					e_bad = e_bad || !EXT_M;
				end else begin
					e_alu = alu_for_f3(f3, f7 == 7'h20);
					e_bad = e_bad || !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
				end
			end
			5'b00011: begin
				if (w == 32'h0000_100f) begin
					e_exc = EXC_REFETCH;
					e_fence = 1'b1;
				end else if (f3 == 3'd0 && e_rs1 == '0 && e_rd == '0) begin
					e_rs2 = '0;
				end else begin
					e_bad = 1'b1;
				end
			end
			5'b11100: begin
				if (f3 == 3'd0) begin
					e_rs1 = '0;
					e_rs2 = '0;
					e_rd = '0;
					case (w)
						32'h0000_0073: e_exc = model_m_mode ? EXC_ECALL_M : EXC_ECALL_U;
						32'h0010_0073: e_exc = EXC_EBREAK;
						32'h3020_0073: begin
							e_exc = EXC_MRET;
							e_bad = e_bad || !model_m_mode;
						end
						32'h1050_0073: begin
							e_wfi = 1'b1;
							e_bad = e_bad || model_trap_wfi;
						end
						default: e_bad = 1'b1;
					endcase
				end else begin
					e_csr = 1'b1;
					e_wimm = f3[2];
					e_wtype = f3[1:0] == 2'b11 ? CSR_C : (f3[1:0] == 2'b10 ? CSR_S : CSR_W);
					e_bad = e_bad || f3[1:0] == 2'b00;
					// CSRRW reads only for rd nonzero, set and clear write only for rs1 nonzero
					e_wen = f3[1:0] == 2'b01 ? 1'b1 : e_rs1 != '0;
					e_ren = f3[1:0] == 2'b01 ? e_rd != '0 : 1'b1;
				end
			end
			default: e_bad = 1'b1;
		endcase
	endtask

	task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			errors++;
			$display("Mismatch %s %s: expected %h, actual %h", phase, what, exp, act);
		end
	endtask

	task automatic check_outputs();
		logic fault;
		fault = instr_vld_i && instr_err_i;
		// illegal, idle or faulted words lose every side effect
		if (e_bad || !instr_vld_i || fault) begin
			e_rs1 = '0;
			e_rs2 = '0;
			e_rd = '0;
			e_mem = MEM_NONE;
			e_bcond = BCOND_NEVER;
			e_ren = 1'b0;
			e_wen = 1'b0;
			e_wfi = 1'b0;
			e_exc = fault ? EXC_INSTR_FAULT : (e_bad && instr_vld_i ? EXC_INSTR_ILLEGAL : EXC_NONE);
		end
		compare("rs1", e_rs1, rs1_o);
		compare("rs2", e_rs2, rs2_o);
		compare("rd", e_rd, rd_o);
		compare("mem_op", e_mem, mem_op_o);
		compare("branch_cond", e_bcond, branch_cond_o);
		compare("csr_ren", e_ren, csr_ren_o);
		compare("csr_wen", e_wen, csr_wen_o);
		compare("except", e_exc, except_o);
		compare("sleep_wfi", e_wfi, sleep_wfi_o);
		compare("addr_offs", e_offs, addr_offs_o);
		compare("fence_i", e_fence, fence_i_o);
		if (!e_bad) begin
			compare("alu_op", e_alu, alu_op_o);
			compare("alu_src_a", e_src_a, alu_src_a_o);
			compare("alu_src_b", e_src_b, alu_src_b_o);
			compare("addr_is_regoffs", e_regoffs, addr_is_regoffs_o);
			if (e_alu == ALU_MULDIV) begin
				compare("mul_op", e_mul, mul_op_o);
			end
			if (e_imm_chk) begin
				compare("imm", e_imm, imm_o);
			end
			if (e_csr) begin
				compare("csr_wtype", e_wtype, csr_wtype_o);
				compare("csr_w_imm", e_wimm, csr_w_imm_o);
			end
		end
		compare("instr_use", instr_vld_i && !x_stall_i, instr_use_o);
		compare("pc", model_pc, pc_o);
		if (jump_now_i) begin
			model_pc = jump_target_i;
		end else if (instr_vld_i && !x_stall_i) begin
			model_pc = model_pc + 32'd4;
		end
	endtask

	task automatic apply_cycle(input logic [31:0] w, input logic v, input logic e,
			input logic s, input logic j, input logic [31:0] tgt);
		@(posedge clk);
		#2;
		instr_i = w;
		instr_vld_i = v;
		instr_err_i = e;
		x_stall_i = s;
		jump_now_i = j;
		jump_target_i = tgt;
		expect_decode(w);
		@(negedge clk);
		check_outputs();
	endtask

	// four-phase write of the privilege bits
	task automatic write_cfg(input logic m, input logic t);
		int waited;
		@(posedge clk);
		#2;
		instr_vld_i = 1'b0;
		jump_now_i = 1'b0;
		cfg_m_mode_i = m;
		cfg_trap_wfi_i = t;
		cfg_req_i = 1'b1;
		waited = 0;
		while (!cfg_ack_o && waited < ACK_TIMEOUT) begin
			@(posedge clk);
			#2;
			waited++;
		end
		assert (cfg_ack_o) else begin
			timeouts++;
			$display("config ack did not rise within %0d cycles", ACK_TIMEOUT);
		end
		cfg_req_i = 1'b0;
		waited = 0;
		while (cfg_ack_o && waited < ACK_TIMEOUT) begin
			@(posedge clk);
			#2;
			waited++;
		end
		assert (!cfg_ack_o) else begin
			timeouts++;
			$display("config ack did not fall within %0d cycles", ACK_TIMEOUT);
		end
		model_m_mode = m;
		model_trap_wfi = t;
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		logic [31:0] word;
		logic [31:0] r;
		logic [31:0] tgt;
		logic        held;
		logic        err;
		clk = 1'b0;
		rst_n = 1'b0;
		instr_i = '0;
		instr_vld_i = 1'b0;
		instr_err_i = 1'b0;
		x_stall_i = 1'b0;
		jump_now_i = 1'b0;
		jump_target_i = '0;
		cfg_req_i = 1'b0;
		cfg_m_mode_i = 1'b0;
		cfg_trap_wfi_i = 1'b0;
		rng_state = 32'd57;
		errors = 0;
		timeouts = 0;
		model_pc = RESET_VEC;
		model_m_mode = 1'b1;
		model_trap_wfi = 1'b0;
		word = '0;
		err = 1'b0;
		held = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;

		phase = "reset";
		apply_cycle(32'h0000_0013, 1'b0, 1'b0, 1'b0, 1'b0, '0);

		// fetch keeps a valid word until decode takes it
		phase = "random";
		for (int n = 0; n < N_RANDOM; n++) begin
			r = next_rand();
			tgt = next_rand();
			if (!held) begin
				word = make_word();
				err = r[3:0] == 4'h0;
			end
			apply_cycle(word, held || r[6:4] != 3'b000, err, r[9:8] == 2'b00,
				r[13:10] == 4'h0, {tgt[31:2], 2'b00});
			held = instr_vld_i && x_stall_i;
		end

		phase = "system";
		for (int c = 0; c < 4; c++) begin
			write_cfg(c[1], c[0] ^ c[1]);
			apply_cycle(32'h0000_0073, 1'b1, 1'b0, 1'b0, 1'b0, '0);
			apply_cycle(32'h0010_0073, 1'b1, 1'b0, 1'b0, 1'b0, '0);
			apply_cycle(32'h3020_0073, 1'b1, 1'b0, 1'b0, 1'b0, '0);
			apply_cycle(32'h1050_0073, 1'b1, 1'b0, 1'b0, 1'b0, '0);
		end

		// fence.i, a plain fence and a fence with a reserved funct3
		phase = "fence";
		apply_cycle(32'h0000_100f, 1'b1, 1'b0, 1'b0, 1'b0, '0);
		apply_cycle(32'h0ff0_000f, 1'b1, 1'b0, 1'b0, 1'b0, '0);
		apply_cycle(32'h0000_200f, 1'b1, 1'b0, 1'b0, 1'b0, '0);

		$display("checks done: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
